/* sim.f */
+incdir+.
qla_pkg.sv
motor_chan_if.sv
qla_write_decode.sv
motor_channel.sv
qla_readback.sv
dac_spi_ctrl.sv
qla_top.sv
tb_qla_top.sv

/* run.sh */
#!/bin/sh
# Compile and run the QLA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_qla_top -o sim_qla

out=$(./obj_dir/sim_qla || true)
echo "$out"

if echo "$out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1

/* tb_qla_top.sv */
// QLA motor controller slice testbench
// Table-driven register writes, read-back checks, amplifier enable and
// fault sequences, and a serial decoder for the quad-DAC frames

`timescale 1ns/1ps
`include "qla_cfg.svh"

module tb_qla_top;

    localparam int FBITS         = `QLA_DAC_FRAME_BITS;
    localparam int PIN_TIMEOUT   = 40;       // Cycles, covers the enable delay
    localparam int FRAME_TIMEOUT = 1000;

    typedef enum logic [2:0] {OP_WR, OP_BLK, OP_RD, OP_FAULT, OP_PIN, OP_FRAMES} op_e;

    typedef struct packed {
        op_e         op;
        logic [15:0] addr;
        logic [31:0] data;     // Write data, fault vector or frame count
        logic [31:0] exp;      // Read value or pin pattern
    } row_t;

    logic        sysclk, arst_n, reg_wen, blk_wen;
    logic [15:0] reg_raddr, reg_waddr;
    logic [31:0] reg_wdata, reg_rdata;
    logic [3:0]  amp_fault, amp_disable_pin;
    logic        dac_sclk, dac_mosi, dac_csel;

    row_t             rows [$];
    logic [FBITS-1:0] exp_q [$];             // Frames the model predicts
    logic [FBITS-1:0] rx_q [$];              // Frames seen on the wire
    logic [FBITS-1:0] rx_shift = '0;
    int               rx_bits = 0;
    int               frames_checked = 0;
    int               err_cnt = 0;
    int               tmo_cnt = 0;
    logic [31:0]      lcg_state = 32'hf617953d;
    logic [31:0]      r;

    // Channel model, index 1..4 as on the bus
    logic [15:0] m_cur [1:4];
    logic        m_en [1:4];
    logic        m_safe [1:4];
    logic        m_fault [1:4];

    qla_top DUT (.*);

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;
    end

    // Fails the run if the sequence never reaches its end
    initial begin
        #100us;
        $display("Watchdog expired before the test sequence finished");
        $display("STATUS: FAIL");
        $finish;
    end

    // ------------------------------------------------------------------------
    // DAC frame decoder
    // ------------------------------------------------------------------------
    always @(posedge dac_sclk) begin
        if (!dac_csel) begin
            if (rx_bits == FBITS - 1) begin
                rx_q.push_back({rx_shift[FBITS-2:0], dac_mosi});
                rx_bits <= 0;
            end else begin
                rx_bits <= rx_bits + 1;
            end
            rx_shift <= {rx_shift[FBITS-2:0], dac_mosi};   // MSB first
        end
    end

    always @(posedge dac_csel) begin
        assert (rx_bits == 0) else begin
            err_cnt++;
            $display("Fail %0t: frame ended after %0d bits", $time, rx_bits);
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [15:0] caddr(input int k, input logic [3:0] off);
        return {`QLA_ADDR_MAIN, 4'h0, 4'(k), off};
    endfunction

    // Status word as the register map defines it
    function automatic logic [31:0] status_exp(input int k);
        logic pin;
        pin = !(m_en[k] && !m_safe[k]);
        return {m_cur[k], 12'd0, pin, m_fault[k], m_safe[k], m_en[k]};
    endfunction

    function automatic logic [31:0] pins_exp();
        logic [31:0] p;
        p = '0;
        for (int k = 1; k <= 4; k++) begin
            p[k-1] = !(m_en[k] && !m_safe[k]);
        end
        return p;
    endfunction

    task automatic add_row(input op_e op, input logic [15:0] addr,
                           input logic [31:0] data, input logic [31:0] exp);
        row_t row;
        row.op   = op;
        row.addr = addr;
        row.data = data;
        row.exp  = exp;
        rows.push_back(row);
    endtask

    task automatic push_frames();
        for (int k = 1; k <= 4; k++) begin
            exp_q.push_back({`QLA_DAC_CMD_WR_UPD, 4'(k - 1), m_cur[k]});
        end
    endtask

    task automatic step();
        @(posedge sysclk);
        #1;                                   // Drive off the edge
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data,
                             input logic blk);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        blk_wen   = blk;
        step();
        reg_wen   = 1'b0;
        blk_wen   = 1'b0;
    endtask

    // Two edges, strobe plus registered read
    task automatic read_check(input logic [15:0] addr, input logic [31:0] exp);
        reg_raddr = addr;
        step();
        step();
        assert (reg_rdata === exp) else begin
            err_cnt++;
            $display("Fail %0t: read 0x%04h returned 0x%08h, expected 0x%08h",
                     $time, addr, reg_rdata, exp);
        end
    endtask

    task automatic wait_pin(input logic [3:0] exp);
        int n;
        n = 0;
        while (amp_disable_pin !== exp && n < PIN_TIMEOUT) begin
            step();
            n++;
        end
        if (amp_disable_pin !== exp) begin
            tmo_cnt++;
            $display("Timeout at %0t: amp_disable_pin stayed %b, waiting for %b",
                     $time, amp_disable_pin, exp);
        end
    endtask

    task automatic check_frames(input int upto);
        int n;
        n = 0;
        while (rx_q.size() < upto && n < FRAME_TIMEOUT) begin
            step();
            n++;
        end
        if (rx_q.size() < upto) begin
            tmo_cnt++;
            $display("Timeout at %0t: only %0d of %0d DAC frames arrived",
                     $time, rx_q.size(), upto);
        end else begin
            for (int i = frames_checked; i < upto; i++) begin
                assert (rx_q[i] === exp_q[i]) else begin
                    err_cnt++;
                    $display("Fail %0t: DAC frame %0d is 0x%06h, expected 0x%06h",
                             $time, i, rx_q[i], exp_q[i]);
                end
            end
            frames_checked = upto;
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------------
    task automatic build_table();
        for (int k = 1; k <= 4; k++) begin
            m_cur[k]   = '0;
            m_en[k]    = 1'b0;
            m_safe[k]  = 1'b0;
            m_fault[k] = 1'b0;
        end
        for (int k = 1; k <= 4; k++) begin      // Reset values
            add_row(OP_RD, caddr(k, `QLA_OFF_DAC_CTRL), '0, '0);
            add_row(OP_RD, caddr(k, `QLA_OFF_MOTOR_STATUS), '0, status_exp(k));
        end
        add_row(OP_RD, 16'h0000, '0, '0);
        for (int k = 1; k <= 4; k++) begin      // Random commanded currents
            r = lcg_next();
            m_cur[k] = r[15:0];
            add_row(OP_WR, caddr(k, `QLA_OFF_DAC_CTRL), r, '0);
            add_row(OP_RD, caddr(k, `QLA_OFF_DAC_CTRL), '0, {16'd0, m_cur[k]});
        end
        // Writes that must be ignored
        add_row(OP_WR, 16'h0001, lcg_next(), '0);
        add_row(OP_WR, 16'h0051, lcg_next(), '0);
        add_row(OP_WR, 16'h00f1, lcg_next(), '0);
        add_row(OP_WR, 16'h1011, lcg_next(), '0);
        add_row(OP_WR, 16'h2021, lcg_next(), '0);
        add_row(OP_WR, 16'h1000, 32'h0000_00ff, '0);   // Global enable, wrong space
        for (int k = 1; k <= 4; k++) begin
            add_row(OP_RD, caddr(k, `QLA_OFF_DAC_CTRL), '0, {16'd0, m_cur[k]});
        end
        add_row(OP_RD, 16'h0051, '0, '0);
        add_row(OP_RD, 16'h1011, '0, '0);               // Other space reads as 0
        add_row(OP_RD, 16'h0012, '0, '0);               // Unmapped channel offset
        add_row(OP_RD, 16'h0000, '0, '0);
        add_row(OP_PIN, '0, '0, pins_exp());

        // Enable channels 1 and 3 only
        m_en[1] = 1'b1;
        m_en[3] = 1'b1;
        add_row(OP_WR, 16'h0000, 32'h0000_0055, '0);
        add_row(OP_PIN, '0, '0, pins_exp());
        add_row(OP_RD, 16'h0000, '0, {28'd0, m_en[4], m_en[3], m_en[2], m_en[1]});
        for (int k = 1; k <= 4; k++) begin
            add_row(OP_RD, caddr(k, `QLA_OFF_MOTOR_STATUS), '0, status_exp(k));
        end

        // Fault on channel 1 latches the safety disable
        m_fault[1] = 1'b1;
        m_safe[1]  = 1'b1;
        add_row(OP_FAULT, '0, 32'h0000_000e, '0);
        add_row(OP_PIN, '0, '0, pins_exp());
        add_row(OP_RD, caddr(1, `QLA_OFF_MOTOR_STATUS), '0, status_exp(1));
        m_fault[1] = 1'b0;
        add_row(OP_FAULT, '0, 32'h0000_000f, '0);
        add_row(OP_RD, caddr(1, `QLA_OFF_MOTOR_STATUS), '0, status_exp(1));
        m_safe[1] = 1'b0;                        // Re-enable clears it
        add_row(OP_WR, 16'h0000, 32'h0000_0011, '0);
        add_row(OP_PIN, '0, '0, pins_exp());
        add_row(OP_RD, caddr(1, `QLA_OFF_MOTOR_STATUS), '0, status_exp(1));

        // DAC update, then a second request while frames are on the wire
        r = lcg_next();
        m_cur[2] = r[15:0];
        add_row(OP_BLK, caddr(2, `QLA_OFF_DAC_CTRL), r, '0);
        push_frames();
        add_row(OP_FRAMES, '0, 32'd1, '0);
        r = lcg_next();
        m_cur[1] = r[15:0];                      // Frame 0 already sent
        add_row(OP_BLK, caddr(1, `QLA_OFF_DAC_CTRL), r, '0);
        push_frames();
        add_row(OP_FRAMES, '0, 32'd8, '0);
    endtask

    initial begin
        arst_n    = 1'b0;
        reg_wen   = 1'b0;
        blk_wen   = 1'b0;
        reg_raddr = '0;
        reg_waddr = '0;
        reg_wdata = '0;
        amp_fault = 4'hf;                       // No fault
        build_table();
        repeat (16) @(posedge sysclk);
        #1;
        arst_n = 1'b1;
        assert (amp_disable_pin === 4'hf && dac_csel === 1'b1 && dac_sclk === 1'b0
                && dac_mosi === 1'b0) else begin
            err_cnt++;
            $display("Fail %0t: outputs not at reset values", $time);
        end

        foreach (rows[i]) begin
            case (rows[i].op)
                OP_WR:     bus_write(rows[i].addr, rows[i].data, 1'b0);
                OP_BLK:    bus_write(rows[i].addr, rows[i].data, 1'b1);
                OP_RD:     read_check(rows[i].addr, rows[i].exp);
                OP_FAULT: begin
                    amp_fault = rows[i].data[3:0];
                    step();
                end
                OP_PIN:    wait_pin(rows[i].exp[3:0]);
                OP_FRAMES: check_frames(int'(rows[i].data));
                default:   step();
            endcase
        end

        // No extra DAC sequence may follow
        repeat (150) step();
        assert (rx_q.size() == exp_q.size()) else begin
            err_cnt++;
            $display("Fail %0t: %0d DAC frames seen, expected %0d",
                     $time, rx_q.size(), exp_q.size());
        end

        $display("Errors: %0d value mismatches, %0d timeouts", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* qla_top.sv */
// QLA motor controller top level
// Register bus into four motor channels, read-back path and
// quad-DAC serial output

`timescale 1ns/1ps
`include "qla_cfg.svh"

module qla_top (
    input  logic        sysclk,
    input  logic        arst_n,
    input  logic        reg_wen,
    input  logic        blk_wen,
    input  logic [15:0] reg_raddr,
    input  logic [15:0] reg_waddr,
    input  logic [31:0] reg_wdata,
    input  logic [3:0]  amp_fault,        // Active low, channel k on bit k-1
    output logic [31:0] reg_rdata,
    output logic [3:0]  amp_disable_pin,
    output logic        dac_sclk,
    output logic        dac_mosi,
    output logic        dac_csel
);

    logic dac_req;

    motor_chan_if chan_bus [`QLA_NUM_CHAN] ();

    qla_write_decode u_wdec (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_wen   (reg_wen),
        .blk_wen   (blk_wen),
        .chan      (chan_bus),
        .dac_req   (dac_req)
    );

    // Axes 1..4
    for (genvar k = 0; k < `QLA_NUM_CHAN; k++) begin : g_mchan
        motor_channel u_mchan (
            .sysclk          (sysclk),
            .arst_n          (arst_n),
            .bus             (chan_bus[k]),
            .amp_fault       (amp_fault[k]),
            .amp_disable_pin (amp_disable_pin[k])
        );
    end

    qla_readback u_rdback (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .reg_raddr (reg_raddr),
        .chan      (chan_bus),
        .reg_rdata (reg_rdata)
    );

    dac_spi_ctrl u_dac (
        .sysclk   (sysclk),
        .arst_n   (arst_n),
        .dac_req  (dac_req),
        .chan     (chan_bus),
        .dac_sclk (dac_sclk),
        .dac_mosi (dac_mosi),
        .dac_csel (dac_csel)
    );

endmodule

/* dac_spi_ctrl.sv */
// Quad-DAC serial controller
// On request sends four 24-bit write-and-update frames, one per channel,
// MSB first at sysclk/2. A request during a sequence is held pending

`timescale 1ns/1ps
`include "qla_cfg.svh"

module dac_spi_ctrl (
    input  logic        sysclk,
    input  logic        arst_n,
    input  logic        dac_req,
    motor_chan_if.drain chan [`QLA_NUM_CHAN],
    output logic        dac_sclk,
    output logic        dac_mosi,
    output logic        dac_csel
);

    localparam int N      = `QLA_NUM_CHAN;
    localparam int FBITS  = `QLA_DAC_FRAME_BITS;
    localparam int FRM_W  = $clog2(N);
    localparam int BIT_W  = $clog2(FBITS);
    localparam int GAP_W  = $clog2(`QLA_DAC_GAP + 1);

    qla_pkg::dac_state_e state;
    logic                req_pend;        // Update waiting to start
    logic [FRM_W-1:0]    frame_cnt;       // Channel minus 1
    logic [BIT_W-1:0]    bit_cnt;
    logic [GAP_W-1:0]    gap_cnt;
    logic [FBITS-1:0]    shreg;           // MSB on the wire
    logic [FBITS-1:0]    frame_word [N];
    logic                start;

    // cmd, address, data
    for (genvar i = 0; i < N; i++) begin : g_frame
        assign frame_word[i] = {`QLA_DAC_CMD_WR_UPD, 4'(i), chan[i].cur_cmd};
    end

    assign start    = (state == qla_pkg::DAC_IDLE) && req_pend;
    assign dac_mosi = shreg[FBITS-1];

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            req_pend <= 1'b0;
        end else begin
            req_pend <= dac_req || (req_pend && !start);
        end
    end

    // ------------------------------------------------------------------------
    // Frame sequencer
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= qla_pkg::DAC_IDLE;
            frame_cnt <= '0;
            bit_cnt   <= '0;
            gap_cnt   <= '0;
            shreg     <= '0;
            dac_sclk  <= 1'b0;
            dac_csel  <= 1'b1;
        end else begin
            case (state)
                qla_pkg::DAC_IDLE: begin
                    if (req_pend) begin
                        state     <= qla_pkg::DAC_SHIFT;
                        frame_cnt <= '0;
                        bit_cnt   <= '0;
                        shreg     <= frame_word[0];      // Latch cur_cmd now
                        dac_csel  <= 1'b0;
                    end
                end
                qla_pkg::DAC_SHIFT: begin
                    dac_sclk <= !dac_sclk;
                    if (dac_sclk) begin                  // Falling edge, next bit
                        shreg <= shreg << 1;
                        if (bit_cnt == BIT_W'(FBITS - 1)) begin
                            state    <= qla_pkg::DAC_GAP;
                            gap_cnt  <= GAP_W'(`QLA_DAC_GAP - 1);
                            dac_csel <= 1'b1;            // Frame ends here
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                qla_pkg::DAC_GAP: begin
                    if (gap_cnt != '0) begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end else if (frame_cnt == FRM_W'(N - 1)) begin
                        state <= qla_pkg::DAC_IDLE;      // Pending req restarts
                    end else begin
                        state     <= qla_pkg::DAC_SHIFT;
                        frame_cnt <= frame_cnt + 1'b1;
                        bit_cnt   <= '0;
                        shreg     <= frame_word[frame_cnt + 1'b1];
                        dac_csel  <= 1'b0;
                    end
                end
                default: state <= qla_pkg::DAC_IDLE;
            endcase
        end
    end

    // Clock edges only inside a selected frame
    a_sclk_in_frame : assert property (@(posedge sysclk) disable iff (!arst_n)
        (dac_sclk != $past(dac_sclk)) |-> !$past(dac_csel));

endmodule

/* qla_readback.sv */
// QLA register read-back
// Registered read mux over the global status and the per-channel
// commanded current and status words

`timescale 1ns/1ps
`include "qla_cfg.svh"

module qla_readback (
    input  logic               sysclk,
    input  logic               arst_n,
    input  qla_pkg::reg_addr_t reg_raddr,
    motor_chan_if.drain        chan [`QLA_NUM_CHAN],
    output qla_pkg::reg_data_t reg_rdata
);

    localparam int N     = `QLA_NUM_CHAN;
    localparam int IDX_W = $clog2(N);

    qla_pkg::cur_cmd_t  cur_cmd_a [N];
    qla_pkg::reg_data_t status_a  [N];
    logic [N-1:0]       en_bits;          // Enable commands, channels N..1
    qla_pkg::chan_num_t rchan;
    logic [IDX_W-1:0]   ridx;             // Channel minus 1
    logic               rd_main;
    qla_pkg::reg_data_t rd_next;

    for (genvar i = 0; i < N; i++) begin : g_chan
        assign cur_cmd_a[i] = chan[i].cur_cmd;
        assign status_a[i]  = chan[i].status;
        assign en_bits[i]   = chan[i].status[0];
    end

    assign rchan   = reg_raddr[7:4];
    assign ridx    = IDX_W'(rchan - 4'd1);
    assign rd_main = (reg_raddr[15:12] == `QLA_ADDR_MAIN);

    always_comb begin
        rd_next = '0;                                  // Unmapped reads as 0
        if (rd_main && rchan == '0 && reg_raddr[3:0] == `QLA_OFF_GLOBAL_STATUS) begin
            rd_next = {{(32 - N){1'b0}}, en_bits};
        end else if (rd_main && rchan != '0 && rchan <= qla_pkg::chan_num_t'(N)) begin
            case (reg_raddr[3:0])
                `QLA_OFF_DAC_CTRL:     rd_next = {16'd0, cur_cmd_a[ridx]};
                `QLA_OFF_MOTOR_STATUS: rd_next = status_a[ridx];
                default:               rd_next = '0;
            endcase
        end
    end

    // One cycle read latency
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rd_next;
        end
    end

endmodule

/* motor_channel.sv */
// Motor channel, one axis
// Holds the commanded current and runs the amplifier enable FSM with
// its enable delay and the latched safety disable on amp fault

`timescale 1ns/1ps
`include "qla_cfg.svh"

module motor_channel (
    input  logic       sysclk,
    input  logic       arst_n,
    motor_chan_if.chan bus,
    input  logic       amp_fault,        // Active low
    output logic       amp_disable_pin
);

    localparam int DLY_W = $clog2(`QLA_AMP_EN_DELAY + 1);

    qla_pkg::amp_state_e amp_state;
    logic [DLY_W-1:0]    dly_cnt;        // Cycles left in AMP_DELAY
    logic                en_cmd;         // Last enable written by host
    logic                fault;
    logic                safety_off;
    qla_pkg::cur_cmd_t   cur_cmd_q;

    assign fault      = !amp_fault;
    assign safety_off = (amp_state == qla_pkg::AMP_SAFETY_OFF);

    // Commanded current
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            cur_cmd_q <= '0;
        end else if (bus.cmd_wen) begin
            cur_cmd_q <= bus.cmd_data;
        end
    end

    // ------------------------------------------------------------------------
    // Amplifier enable FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            amp_state <= qla_pkg::AMP_OFF;
            dly_cnt   <= '0;
            en_cmd    <= 1'b0;
        end else begin
            if (bus.en_wen) begin
                en_cmd <= bus.en_value;
            end
            if (bus.en_wen && !bus.en_value) begin
                amp_state <= qla_pkg::AMP_OFF;              // Disable wins from anywhere
            end else if (bus.en_wen && (amp_state == qla_pkg::AMP_OFF || safety_off)) begin
                amp_state <= qla_pkg::AMP_DELAY;            // Enable clears safety too
                dly_cnt   <= DLY_W'(`QLA_AMP_EN_DELAY - 1);
            end else begin
                case (amp_state)
                    qla_pkg::AMP_DELAY: begin
                        if (fault) begin
                            amp_state <= qla_pkg::AMP_SAFETY_OFF;
                        end else if (dly_cnt == '0) begin
                            amp_state <= qla_pkg::AMP_ON;
                        end else begin
                            dly_cnt <= dly_cnt - 1'b1;
                        end
                    end
                    qla_pkg::AMP_ON: begin
                        if (fault) begin
                            amp_state <= qla_pkg::AMP_SAFETY_OFF;   // Latched
                        end
                    end
                    default: ;                              // OFF, SAFETY_OFF hold
                endcase
            end
        end
    end

    assign amp_disable_pin = (amp_state != qla_pkg::AMP_ON);

    // Status: [31:16] cur_cmd, [3] pin, [2] fault, [1] safety, [0] enable
    assign bus.cur_cmd = cur_cmd_q;
    assign bus.status  = {cur_cmd_q, 12'd0, amp_disable_pin, fault, safety_off, en_cmd};

    // Amp driven only in AMP_ON, and only with the host enable standing
    a_pin_low_on : assert property (@(posedge sysclk) disable iff (!arst_n)
        !amp_disable_pin |-> (amp_state == qla_pkg::AMP_ON) && en_cmd);

endmodule

/* qla_write_decode.sv */
// QLA register write decoder
// Turns bus writes into registered per-channel strobes, so the
// channels never see addresses. Also raises the DAC update request

`timescale 1ns/1ps
`include "qla_cfg.svh"

module qla_write_decode (
    input  logic               sysclk,
    input  logic               arst_n,
    input  qla_pkg::reg_addr_t reg_waddr,
    input  qla_pkg::reg_data_t reg_wdata,
    input  logic               reg_wen,
    input  logic               blk_wen,
    motor_chan_if.decode       chan [`QLA_NUM_CHAN],
    output logic               dac_req
);

    localparam int N = `QLA_NUM_CHAN;

    qla_pkg::chan_num_t wchan;
    logic               wr_main;     // Write into main space
    logic               wr_dac;      // Commanded current, channel 1..N
    logic               wr_glob;     // Global enable write on channel 0
    logic [N-1:0]       cmd_wen_q;
    logic [N-1:0]       en_wen_q;
    logic [N-1:0]       en_val_q;    // Enable values, one per channel
    qla_pkg::cur_cmd_t  cmd_data_q;  // Shared by all channels

    assign wchan   = reg_waddr[7:4];
    assign wr_main = reg_wen && (reg_waddr[15:12] == `QLA_ADDR_MAIN);
    assign wr_dac  = wr_main && (wchan != '0) && (wchan <= qla_pkg::chan_num_t'(N))
                     && (reg_waddr[3:0] == `QLA_OFF_DAC_CTRL);
    assign wr_glob = wr_main && (wchan == '0)
                     && (reg_waddr[3:0] == `QLA_OFF_GLOBAL_STATUS);

    // Strobes, one cycle after the write
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_wen_q <= '0;
            en_wen_q  <= '0;
            dac_req   <= 1'b0;
        end else begin
            dac_req <= wr_dac && blk_wen;   // Block write also updates DAC
            for (int i = 0; i < N; i++) begin
                cmd_wen_q[i] <= wr_dac && (wchan == qla_pkg::chan_num_t'(i + 1));
                en_wen_q[i]  <= wr_glob && reg_wdata[4 + i];   // Mask in [7:4]
            end
        end
    end

    // Payload alongside the strobes
    always_ff @(posedge sysclk) begin
        if (wr_dac) begin
            cmd_data_q <= reg_wdata[15:0];
        end
        if (wr_glob) begin
            en_val_q <= reg_wdata[N-1:0];   // Values in [3:0]
        end
    end

    for (genvar i = 0; i < N; i++) begin : g_chan
        assign chan[i].cmd_wen  = cmd_wen_q[i];
        assign chan[i].cmd_data = cmd_data_q;
        assign chan[i].en_wen   = en_wen_q[i];
        assign chan[i].en_value = en_val_q[i];
    end

    // One channel per current write
    a_one_cmd_wen : assert property (@(posedge sysclk) disable iff (!arst_n)
        $onehot0(cmd_wen_q));

endmodule

/* motor_chan_if.sv */
// Motor channel link
// Write strobes from the decoder into one axis, and the axis state
// back out to the read-back mux and the DAC controller

`timescale 1ns/1ps

interface motor_chan_if;

    logic              cmd_wen;    // Load new commanded current
    qla_pkg::cur_cmd_t cmd_data;
    logic              en_wen;     // Amplifier enable write
    logic              en_value;   // 1 -> enable, 0 -> disable
    qla_pkg::cur_cmd_t cur_cmd;    // Held commanded current
    qla_pkg::reg_data_t status;    // Motor status word

    modport decode (
        output cmd_wen, cmd_data, en_wen, en_value
    );

    modport chan (
        input  cmd_wen, cmd_data, en_wen, en_value,
        output cur_cmd, status
    );

    // Read-back mux and DAC controller
    modport drain (
        input cur_cmd, status
    );

endinterface

/* qla_pkg.sv */
// QLA shared types
// Bus words, commanded current, channel number and FSM state encodings

package qla_pkg;

    // Bus address: [15:12] space, [7:4] channel, [3:0] offset
    typedef logic [15:0] reg_addr_t;

    typedef logic [31:0] reg_data_t;   // Bus data word

    typedef logic [15:0] cur_cmd_t;    // Commanded current, DAC code

    typedef logic [3:0]  chan_num_t;   // Channel number on the bus

    // Amplifier enable FSM
    typedef enum logic [1:0] {
        AMP_OFF,                       // Disabled by command
        AMP_DELAY,                     // Waiting out the enable delay
        AMP_ON,                        // Amplifier driven
        AMP_SAFETY_OFF                 // Latched off after a fault
    } amp_state_e;

    // Quad-DAC serial FSM
    typedef enum logic [1:0] {
        DAC_IDLE,
        DAC_SHIFT,                     // Frame on the wire
        DAC_GAP                        // csel high between frames
    } dac_state_e;

endpackage

/* qla_cfg.svh */
// QLA motor controller slice configuration
// Channel count, register map, amplifier enable delay and quad-DAC framing

`ifndef QLA_CFG_SVH
`define QLA_CFG_SVH

// ---------------------------------------------------------------------------
// Register map
// ---------------------------------------------------------------------------
`define QLA_NUM_CHAN           4        // Motor channels, 1..4 on the bus
`define QLA_ADDR_MAIN          4'h0     // Address space in bits 15..12
`define QLA_OFF_GLOBAL_STATUS  4'd0     // Channel 0 only
`define QLA_OFF_DAC_CTRL       4'd1     // Commanded current
`define QLA_OFF_MOTOR_STATUS   4'd12    // Per-channel status word

// ---------------------------------------------------------------------------
// Amplifier and DAC timing
// ---------------------------------------------------------------------------
`define QLA_AMP_EN_DELAY       8        // sysclk cycles in AMP_DELAY
`define QLA_DAC_FRAME_BITS     24       // cmd + addr + data
`define QLA_DAC_CMD_WR_UPD     4'b0011  // Write and update DAC register
`define QLA_DAC_GAP            2        // Chip select high between frames

`endif
